/* Bender.yml */
package:
  name: mesh_router

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/mesh_pkg.sv
      - mesh/mesh_rr_arbiter.sv
      - mesh/mesh_input_unit.sv
      - mesh/mesh_switch_control.sv
      - mesh/mesh_crossbar.sv
      - mesh/mesh_router.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verification/mesh_router_assert.sv
      - verification/mesh_router_tb.sv

/* common/mesh_macros.svh */
// ####################
// Mesh router constants
// Port count, flit and coordinate widths, FIFO depth
// ####################

`ifndef MESH_MACROS_SVH
`define MESH_MACROS_SVH

// Centre, north, east, south, west
`define MESH_NUM_PORTS 5

// Single-flit packet width
`define MESH_FLIT_W 16

// One coordinate, 4x4 mesh
`define MESH_COORD_W 2

// Entries per input FIFO
`define MESH_FIFO_DEPTH 4

`endif

/* common/mesh_pkg.sv */
// ####################
// Mesh router package
// Port direction encoding and flit field layout
// ####################

`include "mesh_macros.svh"

package mesh_pkg;

  // Port index, also the crossbar select code
  typedef enum logic [2:0] {
    PORT_C = 3'd0,  // Local node
    PORT_N = 3'd1,
    PORT_E = 3'd2,
    PORT_S = 3'd3,
    PORT_W = 3'd4
  } port_dir_e;

  // Destination column, top bits of the flit
  localparam int DEST_X_HI = `MESH_FLIT_W - 1;
  localparam int DEST_X_LO = DEST_X_HI - `MESH_COORD_W + 1;

  // Destination row
  localparam int DEST_Y_HI = DEST_X_LO - 1;
  localparam int DEST_Y_LO = DEST_Y_HI - `MESH_COORD_W + 1;

  // Injecting input port, payload only
  localparam int SRC_PORT_HI = DEST_Y_LO - 1;
  localparam int SRC_PORT_LO = SRC_PORT_HI - 2;

  // Sequence number, rest of the flit
  localparam int SEQ_HI = SRC_PORT_LO - 1;
  localparam int SEQ_LO = 0;

endpackage

/* list.f */
+incdir+common
common/mesh_pkg.sv
mesh/mesh_rr_arbiter.sv
mesh/mesh_input_unit.sv
mesh/mesh_switch_control.sv
mesh/mesh_crossbar.sv
mesh/mesh_router.sv
verification/mesh_router_assert.sv
verification/mesh_router_tb.sv

/* mesh/mesh_crossbar.sv */
// ####################
// Registered crossbar
// Five 5-to-1 flit muxes into output registers
// ####################

`timescale 1ns/1ps
`include "mesh_macros.svh"

module mesh_crossbar (
  input  logic                    clk,
  input  logic                    i_arst_n,
  input  logic [`MESH_FLIT_W-1:0] i_flit  [`MESH_NUM_PORTS],  // Input FIFO heads
  input  mesh_pkg::port_dir_e     i_sel   [`MESH_NUM_PORTS],  // Source per output
  input  logic                    i_valid [`MESH_NUM_PORTS],
  output logic [`MESH_FLIT_W-1:0] o_flit  [`MESH_NUM_PORTS],  // To downstream links
  output logic                    o_valid [`MESH_NUM_PORTS]   // One-cycle pulse per flit
);

  localparam int N = `MESH_NUM_PORTS;

  logic [`MESH_FLIT_W-1:0] mux_flit [N];

  // Select per output
  always_comb begin
    for (int j = 0; j < N; j++) begin
      mux_flit[j] = i_flit[i_sel[j]];
    end
  end

  // Valid pulses
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int j = 0; j < N; j++) begin
        o_valid[j] <= 1'b0;
      end
    end else begin
      for (int j = 0; j < N; j++) begin
        o_valid[j] <= i_valid[j];
      end
    end
  end

  // Payload held between flits
  always_ff @(posedge clk) begin
    for (int j = 0; j < N; j++) begin
      if (i_valid[j]) begin
        o_flit[j] <= mux_flit[j];
      end
    end
  end

endmodule

/* mesh/mesh_input_unit.sv */
// ####################
// Mesh input unit
// Flit FIFO per port, XY route on the head flit
// Raises stop upstream when full
// ####################

`timescale 1ns/1ps
`include "mesh_macros.svh"

module mesh_input_unit #(
  parameter int P_X = 0,  // Own column
  parameter int P_Y = 0   // Own row
) (
  input  logic                       clk,
  input  logic                       i_arst_n,
  input  logic [`MESH_FLIT_W-1:0]    i_flit,       // From upstream link
  input  logic                       i_valid,
  input  logic                       i_enable,     // Pop head at next edge
  output logic                       o_stop,       // FIFO full
  output logic [`MESH_FLIT_W-1:0]    o_head_flit,  // To crossbar
  output logic [`MESH_NUM_PORTS-1:0] o_req         // One-hot output request
);

  localparam int PTR_W = $clog2(`MESH_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`MESH_FIFO_DEPTH + 1);

  // Own coordinates at field width
  localparam logic [`MESH_COORD_W-1:0] L_X = P_X[`MESH_COORD_W-1:0];
  localparam logic [`MESH_COORD_W-1:0] L_Y = P_Y[`MESH_COORD_W-1:0];

  logic [`MESH_FLIT_W-1:0]  mem [`MESH_FIFO_DEPTH];
  logic [PTR_W-1:0]         wr_ptr;
  logic [PTR_W-1:0]         rd_ptr;
  logic [CNT_W-1:0]         count;   // Occupancy
  logic                     full;
  logic                     empty;
  logic                     push;
  logic                     pop;
  logic [`MESH_COORD_W-1:0] dest_x;
  logic [`MESH_COORD_W-1:0] dest_y;

  assign full  = (count == CNT_W'(`MESH_FIFO_DEPTH));
  assign empty = (count == '0);
  assign push  = i_valid && !full;    // Full FIFO takes nothing
  assign pop   = i_enable && !empty;

  assign o_stop      = full;
  assign o_head_flit = mem[rd_ptr];  // Head visible the cycle after first write

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= i_flit;
    end
  end

  // Pointers and count, wrap at depth
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(`MESH_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`MESH_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle or push with pop
      endcase
    end
  end

  // Destination fields of the head
  assign dest_x = o_head_flit[mesh_pkg::DEST_X_HI:mesh_pkg::DEST_X_LO];
  assign dest_y = o_head_flit[mesh_pkg::DEST_Y_HI:mesh_pkg::DEST_Y_LO];

  // XY routing, X resolved first
  always_comb begin
    o_req = '0;
    if (!empty) begin
      if (dest_x > L_X) begin
        o_req[mesh_pkg::PORT_E] = 1'b1;
      end else if (dest_x < L_X) begin
        o_req[mesh_pkg::PORT_W] = 1'b1;
      end else if (dest_y > L_Y) begin
        o_req[mesh_pkg::PORT_N] = 1'b1;
      end else if (dest_y < L_Y) begin
        o_req[mesh_pkg::PORT_S] = 1'b1;
      end else begin
        o_req[mesh_pkg::PORT_C] = 1'b1;  // Arrived, eject locally
      end
    end
  end

endmodule

/* mesh/mesh_router.sv */
// ####################
// Mesh router top
// Five input units, switch control, crossbar
// Position set by P_X and P_Y
// ####################

`timescale 1ns/1ps
`include "mesh_macros.svh"

module mesh_router #(
  parameter int P_X = 0,  // Column in the mesh
  parameter int P_Y = 0   // Row in the mesh
) (
  input  logic                    clk,
  input  logic                    i_arst_n,
  input  logic [`MESH_FLIT_W-1:0] i_flit  [`MESH_NUM_PORTS],  // Upstream flits
  input  logic                    i_valid [`MESH_NUM_PORTS],
  input  logic                    i_stop  [`MESH_NUM_PORTS],  // Downstream hold
  output logic                    o_stop  [`MESH_NUM_PORTS],  // Hold upstream
  output logic [`MESH_FLIT_W-1:0] o_flit  [`MESH_NUM_PORTS],  // Downstream flits
  output logic                    o_valid [`MESH_NUM_PORTS]
);

  localparam int N = `MESH_NUM_PORTS;

  logic [`MESH_FLIT_W-1:0] head_flit  [N];  // FIFO heads into crossbar
  logic [N-1:0]            req        [N];  // Route requests per input
  logic                    enable     [N];  // FIFO pops
  mesh_pkg::port_dir_e     sel        [N];  // Crossbar selects
  logic                    xbar_valid [N];
  logic [N-1:0]            stop_vec;        // Downstream stops, packed

  // Input side, one unit per port
  generate
    for (genvar p = 0; p < N; p++) begin : gen_in
      assign stop_vec[p] = i_stop[p];

      mesh_input_unit #(
        .P_X (P_X),
        .P_Y (P_Y)
      ) i_mesh_input_unit (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_flit      (i_flit[p]),
        .i_valid     (i_valid[p]),
        .i_enable    (enable[p]),
        .o_stop      (o_stop[p]),
        .o_head_flit (head_flit[p]),
        .o_req       (req[p])
      );
    end
  endgenerate

  // Arbitration
  mesh_switch_control i_mesh_switch_control (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_stop       (stop_vec),
    .i_req_output (req),
    .o_sel        (sel),
    .o_enable     (enable),
    .o_valid      (xbar_valid)
  );

  // Output registers
  mesh_crossbar i_mesh_crossbar (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_flit   (head_flit),
    .i_sel    (sel),
    .i_valid  (xbar_valid),
    .o_flit   (o_flit),
    .o_valid  (o_valid)
  );

endmodule

/* mesh/mesh_rr_arbiter.sv */
// ####################
// Round-robin arbiter
// Five requesters, rotating priority pointer
// ####################

`timescale 1ns/1ps
`include "mesh_macros.svh"

module mesh_rr_arbiter (
  input  logic                       clk,
  input  logic                       i_arst_n,
  input  logic [`MESH_NUM_PORTS-1:0] i_request,  // Bit i from input i
  output logic [`MESH_NUM_PORTS-1:0] o_grant     // At most one bit set
);

  localparam int N     = `MESH_NUM_PORTS;
  localparam int PTR_W = $clog2(N);

  logic [PTR_W-1:0] ptr;        // Highest priority index
  logic [PTR_W-1:0] grant_idx;  // Index of the winner

  // Search from the pointer, wrapping past the last requester
  always_comb begin
    int   idx;
    logic found;
    o_grant   = '0;
    grant_idx = ptr;
    found     = 1'b0;
    for (int off = 0; off < N; off++) begin
      idx = int'(ptr) + off;
      if (idx >= N) begin
        idx = idx - N;  // Wrap
      end
      if (!found && i_request[idx]) begin
        found        = 1'b1;
        o_grant[idx] = 1'b1;
        grant_idx    = PTR_W'(idx);
      end
    end
  end

  // Winner drops to lowest priority
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ptr <= '0;
    end else if (|o_grant) begin
      ptr <= (grant_idx == PTR_W'(N - 1)) ? '0 : grant_idx + 1'b1;
    end
  end

endmodule

/* mesh/mesh_switch_control.sv */
// ####################
// Switch control
// Stop masking, one arbiter per output
// Enables, crossbar selects, valids
// ####################

`timescale 1ns/1ps
`include "mesh_macros.svh"

module mesh_switch_control (
  input  logic                       clk,
  input  logic                       i_arst_n,
  input  logic [`MESH_NUM_PORTS-1:0] i_stop,                          // Downstream hold per output
  input  logic [`MESH_NUM_PORTS-1:0] i_req_output [`MESH_NUM_PORTS],  // Per input, one-hot output
  output mesh_pkg::port_dir_e        o_sel        [`MESH_NUM_PORTS],  // Per output, chosen input
  output logic                       o_enable     [`MESH_NUM_PORTS],  // Pop input FIFO
  output logic                       o_valid      [`MESH_NUM_PORTS]   // Flit goes out on output
);

  localparam int N = `MESH_NUM_PORTS;

  logic [N-1:0] req_col   [N];  // Requests seen by output j, bit i from input i
  logic [N-1:0] grant_col [N];  // Grants from output j

  // Transpose requests into columns, drop stopped outputs
  always_comb begin
    for (int j = 0; j < N; j++) begin
      for (int i = 0; i < N; i++) begin
        req_col[j][i] = i_req_output[i][j] && !i_stop[j];
      end
    end
  end

  // One arbiter per output
  generate
    for (genvar j = 0; j < N; j++) begin : gen_arb
      mesh_rr_arbiter i_mesh_rr_arbiter (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .i_request (req_col[j]),
        .o_grant   (grant_col[j])
      );
    end
  endgenerate

  // Output valid from any grant in the column
  // Input enable from any grant naming that input
  always_comb begin
    for (int j = 0; j < N; j++) begin
      o_valid[j] = |grant_col[j];
    end
    for (int i = 0; i < N; i++) begin
      o_enable[i] = 1'b0;
      for (int j = 0; j < N; j++) begin
        o_enable[i] = o_enable[i] | grant_col[j][i];  // Input requests one output only
      end
    end
  end

  // Encode the winner for the crossbar
  always_comb begin
    for (int j = 0; j < N; j++) begin
      o_sel[j] = mesh_pkg::PORT_C;  // Don't care when idle
      for (int i = 0; i < N; i++) begin
        if (grant_col[j][i]) begin
          o_sel[j] = mesh_pkg::port_dir_e'(3'(i));
        end
      end
    end
  end

endmodule

/* verification/mesh_router_assert.sv */
// ####################
// Switch control checks
// One-hot grants, stops respected,
// enables matched by selects
// ####################

`timescale 1ns/1ps
`include "mesh_macros.svh"

module mesh_router_assert (
  input logic                       clk,
  input logic                       i_arst_n,
  input logic [`MESH_NUM_PORTS-1:0] i_stop,                         // Downstream stops
  input logic [`MESH_NUM_PORTS-1:0] i_grant_col [`MESH_NUM_PORTS],  // Arbiter grants
  input mesh_pkg::port_dir_e        i_sel       [`MESH_NUM_PORTS],
  input logic                       i_enable    [`MESH_NUM_PORTS],
  input logic                       i_valid     [`MESH_NUM_PORTS]
);

  localparam int N = `MESH_NUM_PORTS;

  logic [N-1:0] picked;  // Inputs named by a valid output
  int unsigned  fail_count = 0;  // Assertion failures so far

  always_comb begin
    picked = '0;
    for (int j = 0; j < N; j++) begin
      if (i_valid[j]) begin
        picked[i_sel[j]] = 1'b1;
      end
    end
  end

  generate
    for (genvar j = 0; j < N; j++) begin : gen_chk
      grant_onehot: assert property (@(posedge clk) disable iff (!i_arst_n)
        $onehot0(i_grant_col[j]))
        else begin
          $error("output %0d granted more than one input", j);
          fail_count++;
        end
      stop_blocks_valid: assert property (@(posedge clk) disable iff (!i_arst_n)
        !(i_valid[j] && i_stop[j]))
        else begin
          $error("output %0d valid while stopped", j);
          fail_count++;
        end
      enable_selected: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_enable[j] |-> picked[j])
        else begin
          $error("input %0d popped without any output selecting it", j);
          fail_count++;
        end
    end
  endgenerate

endmodule

bind mesh_switch_control mesh_router_assert i_mesh_router_assert (
  .clk         (clk),
  .i_arst_n    (i_arst_n),
  .i_stop      (i_stop),
  .i_grant_col (grant_col),
  .i_sel       (o_sel),
  .i_enable    (o_enable),
  .i_valid     (o_valid)
);

/* verification/mesh_router_golden.txt */
# I src dest_x dest_y seq out | S out delay len | F out deliveries
# O port o_stop_level | D waits until every pending flit is delivered
I 0 0 0 1 4
I 0 1 0 2 3
I 0 2 0 3 2
I 1 0 1 4 4
I 1 1 1 5 0
I 1 2 1 6 2
I 3 0 2 7 4
I 3 1 2 8 1
I 3 2 2 9 2
D
S 1 1 40
I 4 1 2 10 1
I 4 1 3 11 1
D
S 2 1 80
F 2 8
I 0 2 1 12 2
I 0 2 2 13 2
I 0 3 1 14 2
I 0 3 3 15 2
O 0 1
I 1 2 0 16 2
I 3 3 0 17 2
I 4 2 3 18 2
I 1 3 2 19 2
I 3 2 1 20 2
I 4 3 3 21 2
D

/* verification/mesh_router_tb.sv */
// ####################
// Mesh router testbench
// Golden-file stimulus, XY reference model, scoreboard
// ####################

`timescale 1ns/1ps
`include "mesh_macros.svh"

module mesh_router_tb;

  localparam int N           = `MESH_NUM_PORTS;
  localparam int ROUTER_X    = 1;
  localparam int ROUTER_Y    = 1;
  localparam int WAIT_LIMIT  = 200;  // Cycles for a stop to fall
  localparam int DRAIN_LIMIT = 400;  // Cycles for all pending flits

  logic                    clk = 1'b0;
  logic                    i_arst_n;
  logic [`MESH_FLIT_W-1:0] i_flit  [N];
  logic                    i_valid [N];
  logic                    i_stop  [N] = '{default: 1'b0};
  logic                    o_stop  [N];
  logic [`MESH_FLIT_W-1:0] o_flit  [N];
  logic                    o_valid [N];

  logic [`MESH_FLIT_W-1:0] pend_flit [$];  // Sent and not yet delivered
  int                      pend_out  [$];  // Port from the reference model
  logic [31:0]             lfsr       = 32'h1d3a61b7;
  int                      cyc        = 0;
  int                      stop_from  [N] = '{default: 0};
  int                      stop_until [N] = '{default: 0};
  logic                    stop_seen  [N] = '{default: 1'b0};  // Stop at the last rising edge
  int                      errors     = 0;
  int                      checks     = 0;
  int                      timeouts   = 0;
  int                      fair_port  = 0;
  int                      fair_left  = 0;   // Deliveries still under fairness watch
  int                      fair_count = 0;
  logic [N-1:0]            fair_mask  = '0;  // Sources seen in the current group

  always #20 clk = ~clk;  // 40 ns period

  mesh_router #(
    .P_X (ROUTER_X),
    .P_Y (ROUTER_Y)
  ) i_mesh_router (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_flit   (i_flit),
    .i_valid  (i_valid),
    .i_stop   (i_stop),
    .o_stop   (o_stop),
    .o_flit   (o_flit),
    .o_valid  (o_valid)
  );

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic int random_bits(input int n);
    int v;
    v = 0;
    for (int k = 0; k < n; k++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  // Reference XY rule with X resolved first
  function automatic int xy_route(input int dx, input int dy);
    if (dx > ROUTER_X) return 2;  // East
    if (dx < ROUTER_X) return 4;  // West
    if (dy > ROUTER_Y) return 1;  // North
    if (dy < ROUTER_Y) return 3;  // South
    return 0;
  endfunction

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      $display("FAIL t=%0t %s expected %0h got %0h", $time, name, exp, got);
      errors++;
    end
  endtask

  // Golden record must supply every field
  task automatic check_field_count(input string kind_name, input int got, input int want);
    checks++;
    assert (got == want) else begin
      $display("ERROR t=%0t: %s record in golden file has %0d fields instead of %0d",
               $time, kind_name, got, want);
      errors++;
    end
  endtask

  // Each run of four deliveries must cover four sources
  task automatic count_fair(input int src);
    fair_mask[src] = 1'b1;
    fair_count++;
    fair_left--;
    if (fair_count == 4) begin
      checks++;
      assert ($countones(fair_mask) == 4) else begin
        $display("ERROR t=%0t: four deliveries on output %0d came from only %0d sources",
                 $time, fair_port, $countones(fair_mask));
        errors++;
      end
      fair_count = 0;
      fair_mask  = '0;
    end
  endtask

  // Oldest pending flit with the same source and output must match
  task automatic take_delivery(input int j);
    int src;
    int hit;
    src = int'(o_flit[j][11:9]);
    hit = -1;
    for (int k = 0; k < pend_flit.size(); k++) begin
      if (hit < 0 && pend_out[k] == j && int'(pend_flit[k][11:9]) == src) begin
        hit = k;
      end
    end
    checks++;
    assert (hit >= 0) else begin
      $display("ERROR t=%0t: output %0d delivered flit %h that was never sent there",
               $time, j, o_flit[j]);
      errors++;
    end
    if (hit >= 0) begin
      check_equal($sformatf("o_flit[%0d]", j), o_flit[j], pend_flit[hit]);
      pend_flit.delete(hit);
      pend_out.delete(hit);
      if (fair_left > 0 && j == fair_port) begin
        count_fair(src);
      end
    end
  endtask

  task automatic inject(input int src, input int dx, input int dy, input int seq,
                        input int out);
    logic [`MESH_FLIT_W-1:0] flit;
    int                      route;
    int                      gap;
    int                      t;
    route = xy_route(dx, dy);
    check_equal($sformatf("golden port of seq %0d", seq), out, route);
    flit = {dx[1:0], dy[1:0], src[2:0], seq[8:0]};
    gap  = random_bits(2);
    repeat (gap) @(negedge clk);  // Idle gap
    t = 0;
    while (o_stop[src] && t < WAIT_LIMIT) begin
      @(negedge clk);
      t++;
    end
    if (o_stop[src]) begin
      $display("ERROR t=%0t: stop on input %0d never fell, seq %0d not sent", $time, src, seq);
      timeouts++;
    end else begin
      i_flit[src]  = flit;
      i_valid[src] = 1'b1;
      pend_flit.push_back(flit);
      pend_out.push_back(route);
      @(negedge clk);
      i_valid[src] = 1'b0;
    end
  endtask

  task automatic drain_pending();
    int t;
    t = 0;
    while (pend_flit.size() != 0 && t < DRAIN_LIMIT) begin
      @(negedge clk);
      t++;
    end
    if (pend_flit.size() != 0) begin
      $display("ERROR t=%0t: %0d flits never delivered", $time, pend_flit.size());
      timeouts++;
    end
  endtask

  // Stop schedule from the golden file
  always @(negedge clk) begin
    cyc <= cyc + 1;
    for (int p = 0; p < N; p++) begin
      i_stop[p] <= (cyc >= stop_from[p]) && (cyc < stop_until[p]);
    end
  end

  always @(posedge clk) begin
    for (int p = 0; p < N; p++) begin
      stop_seen[p] <= i_stop[p];
    end
  end

  // Output monitor on outputs settled since the rising edge
  always @(negedge clk) begin
    if (i_arst_n) begin
      for (int j = 0; j < N; j++) begin
        if (stop_seen[j]) begin
          check_equal($sformatf("o_valid[%0d]", j), o_valid[j], 0);  // Held by stop
        end
        if (o_valid[j]) begin
          take_delivery(j);
        end
      end
    end
  end

  initial begin
    int              fd;
    int              n;
    int              f [5];   // Record fields
    int              sva_fails;
    logic [7:0]      kind;
    logic [8*96-1:0] rest;
    i_arst_n = 1'b0;
    for (int p = 0; p < N; p++) begin
      i_flit[p]  = '0;
      i_valid[p] = 1'b0;
    end
    repeat (16) @(negedge clk);
    i_arst_n = 1'b1;
    @(negedge clk);
    for (int p = 0; p < N; p++) begin
      check_equal($sformatf("o_valid[%0d]", p), o_valid[p], 0);
      check_equal($sformatf("o_stop[%0d]", p), o_stop[p], 0);
    end
    fd = $fopen("verification/mesh_router_golden.txt", "r");
    if (fd == 0) begin
      $display("ERROR: golden file could not be opened");
      errors++;
    end else begin
      while (timeouts == 0 && $fscanf(fd, " %c", kind) == 1) begin
        case (kind)
          "#": n = $fgets(rest, fd);  // Column notes
          "I": begin
            n = $fscanf(fd, "%d %d %d %d %d", f[0], f[1], f[2], f[3], f[4]);
            check_field_count("injection", n, 5);
            inject(f[0], f[1], f[2], f[3], f[4]);
          end
          "S": begin
            n = $fscanf(fd, "%d %d %d", f[0], f[1], f[2]);
            check_field_count("stop", n, 3);
            stop_from[f[0]]  = cyc + f[1];
            stop_until[f[0]] = cyc + f[1] + f[2];
          end
          "F": begin
            n = $fscanf(fd, "%d %d", f[0], f[1]);
            check_field_count("fairness", n, 2);
            fair_port  = f[0];
            fair_left  = f[1];
            fair_count = 0;
            fair_mask  = '0;
          end
          "O": begin
            n = $fscanf(fd, "%d %d", f[0], f[1]);
            check_field_count("o_stop level", n, 2);
            @(negedge clk);
            check_equal($sformatf("o_stop[%0d]", f[0]), o_stop[f[0]], f[1]);
          end
          "D": drain_pending();
          default: begin
            $display("ERROR: unknown record type %c in golden file", kind);
            errors++;
          end
        endcase
      end
      $fclose(fd);
    end
    if (timeouts == 0) begin
      drain_pending();
    end
    for (int p = 0; p < N; p++) begin
      check_equal($sformatf("o_stop[%0d]", p), o_stop[p], 0);  // All FIFOs empty again
    end
    sva_fails = i_mesh_router.i_mesh_switch_control.i_mesh_router_assert.fail_count;
    $display("Checks: %0d  errors: %0d  timeouts: %0d  assertion failures: %0d",
             checks, errors, timeouts, sva_fails);
    if (errors == 0 && timeouts == 0 && sva_fails == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
